/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary -j 0 --Mdir obj_dir
TOP       := rob_core_tb
FILELIST  := project.f

SIM     := obj_dir/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* hw/dispatch_unit.sv */
`timescale 1ns/1ps

module dispatch_unit import rob_pkg::*; (
    input  logic      issue_valid,
    output logic      issue_ready,
    input  alu_op_e   issue_op,
    input  word_t     issue_a,
    input  word_t     issue_b,
    input  reg_addr_t issue_rd,

    rob_alloc_if.dispatch alloc,
    lane_issue_if.dispatch lanes [NUM_LANES]
);

    logic [NUM_LANES-1:0] lane_idle;
    lane_idx_t            sel_lane;
    logic                 any_idle;
    logic                 launch;

    // Lowest-numbered idle lane wins
    always_comb begin
        sel_lane = '0;
        any_idle = 1'b0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (lane_idle[i]) begin
                sel_lane = lane_idx_t'(i);
                any_idle = 1'b1;
            end
        end
    end

    // Need both a free buffer entry and a free lane
    assign issue_ready = alloc.ready && any_idle;
    assign launch      = issue_valid && issue_ready;

    // Allocation fires on exactly the same edge as the lane start
    assign alloc.valid = issue_valid && any_idle;
    assign alloc.rd    = issue_rd;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign lane_idle[i] = lanes[i].ready;

        assign lanes[i].valid = launch && (sel_lane == lane_idx_t'(i));
        assign lanes[i].op    = issue_op;
        assign lanes[i].a     = issue_a;
        assign lanes[i].b     = issue_b;
        // Tail index of the buffer becomes the operation's tag
        assign lanes[i].tag   = alloc.tag;
    end

endmodule

/* hw/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane import rob_pkg::*; (
    input  logic clk,
    input  logic reset,

    lane_issue_if.lane issue,

    output logic  done_valid,
    output tag_t  done_tag,
    output word_t done_value
);

    lane_state_e state;
    lat_cnt_t    cnt;
    lat_cnt_t    start_cnt;
    word_t       result_d;
    word_t       result_q;
    tag_t        tag_q;
    logic        accept;

    assign issue.ready = (state == LANE_IDLE);
    assign accept      = issue.valid && issue.ready;

    // Result is formed from the operands at the accepting edge
    always_comb begin
        case (issue.op)
            OP_ADD:  result_d = issue.a + issue.b;
            OP_SUB:  result_d = issue.a - issue.b;
            OP_AND:  result_d = issue.a & issue.b;
            OP_XOR:  result_d = issue.a ^ issue.b;
            // Low XLEN bits of the product
            OP_MUL:  result_d = issue.a * issue.b;
            default: result_d = '0;
        endcase
    end

    // Remaining busy cycles after the first one
    assign start_cnt = (issue.op == OP_MUL) ? lat_cnt_t'(MUL_LATENCY - 1) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LANE_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (accept) begin
                        state <= LANE_BUSY;
                        cnt   <= start_cnt;
                    end
                end
                LANE_BUSY: begin
                    // Completion is sampled on this edge, so go idle with it
                    if (cnt == '0) begin
                        state <= LANE_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    // Payload held for the whole busy period
    always_ff @(posedge clk) begin
        if (accept) begin
            result_q <= result_d;
            tag_q    <= issue.tag;
        end
    end

    assign done_valid = (state == LANE_BUSY) && (cnt == '0);
    assign done_tag   = tag_q;
    assign done_value = result_q;

endmodule

/* hw/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer import rob_pkg::*; (
    input  logic clk,
    input  logic reset,

    rob_alloc_if.buffer alloc,

    // Lane completions, one slot per lane
    input  logic [NUM_LANES-1:0] done_valid,
    input  tag_t                 done_tag [NUM_LANES],
    input  word_t                done_value [NUM_LANES],

    // Register-file write commits, in program order
    output logic      commit_valid,
    input  logic      commit_ready,
    output reg_addr_t commit_rd,
    output word_t     commit_value
);

    reg_addr_t            rd_q [ROB_DEPTH];
    word_t                value_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;

    tag_t   head;
    tag_t   tail;
    count_t count;

    logic full;
    logic empty;
    logic alloc_fire;
    logic commit_fire;

    assign full  = (count == count_t'(ROB_DEPTH));
    assign empty = (count == '0);

    assign alloc.ready = !full;
    assign alloc.tag   = tail;
    assign alloc_fire  = alloc.valid && alloc.ready;

    // Head is committable once its lane has reported
    assign commit_valid = !empty && done_q[head];
    assign commit_rd    = rd_q[head];
    assign commit_value = value_q[head];
    assign commit_fire  = commit_valid && commit_ready;

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_fire) begin
                tail <= tail + 1'b1;
            end
            if (commit_fire) begin
                head <= head + 1'b1;
            end
            case ({alloc_fire, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Done flags
    // Allocated, completing and committing entries never coincide
    always_ff @(posedge clk) begin
        if (reset) begin
            done_q <= '0;
        end else begin
            if (alloc_fire) begin
                done_q[tail] <= 1'b0;
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (done_valid[i]) begin
                    done_q[done_tag[i]] <= 1'b1;
                end
            end
            if (commit_fire) begin
                done_q[head] <= 1'b0;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rd_q[tail] <= alloc.rd;
        end
        // Each in-flight lane owns a distinct tag
        for (int i = 0; i < NUM_LANES; i++) begin
            if (done_valid[i]) begin
                value_q[done_tag[i]] <= done_value[i];
            end
        end
    end

endmodule

/* hw/rob_core.sv */
`timescale 1ns/1ps

module rob_core import rob_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // Issue side, program order
    input  logic      issue_valid,
    output logic      issue_ready,
    input  alu_op_e   issue_op,
    input  word_t     issue_a,
    input  word_t     issue_b,
    input  reg_addr_t issue_rd,

    // Commit side, program order
    output logic      commit_valid,
    input  logic      commit_ready,
    output reg_addr_t commit_rd,
    output word_t     commit_value
);

    rob_alloc_if  alloc_bus ();
    lane_issue_if lane_bus [NUM_LANES] ();

    // Completion pulses from the lanes
    logic [NUM_LANES-1:0] done_valid;
    tag_t                 done_tag [NUM_LANES];
    word_t                done_value [NUM_LANES];

    dispatch_unit u_dispatch (
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_rd    (issue_rd),
        .alloc       (alloc_bus),
        .lanes       (lane_bus)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        exec_lane u_lane (
            .clk        (clk),
            .reset      (reset),
            .issue      (lane_bus[i]),
            .done_valid (done_valid[i]),
            .done_tag   (done_tag[i]),
            .done_value (done_value[i])
        );
    end

    reorder_buffer u_rob (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc_bus),
        .done_valid   (done_valid),
        .done_tag     (done_tag),
        .done_value   (done_value),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

endmodule

/* hw/rob_ifs.sv */
`timescale 1ns/1ps

// Operation handoff from dispatch into one execution lane
interface lane_issue_if import rob_pkg::*; ();

    logic    valid;
    logic    ready;
    alu_op_e op;
    word_t   a;
    word_t   b;
    tag_t    tag;

    modport dispatch (
        output valid,
        output op,
        output a,
        output b,
        output tag,
        input  ready
    );

    modport lane (
        input  valid,
        input  op,
        input  a,
        input  b,
        input  tag,
        output ready
    );

endinterface

// Tag allocation request into the reorder buffer
interface rob_alloc_if import rob_pkg::*; ();

    logic      valid;
    logic      ready;
    reg_addr_t rd;
    tag_t      tag;

    modport dispatch (
        output valid,
        output rd,
        input  ready,
        input  tag
    );

    modport buffer (
        input  valid,
        input  rd,
        output ready,
        output tag
    );

endinterface

/* hw/rob_pkg.sv */
package rob_pkg;

    // Data path
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] word_t;

    // Destination register number
    localparam int REG_ADDR_W = 5;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Reorder buffer geometry, depth kept a power of two so pointers wrap
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W = $clog2(ROB_DEPTH);
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [TAG_W:0] count_t;

    // Execution lanes
    localparam int NUM_LANES = 4;
    localparam int LANE_IDX_W = $clog2(NUM_LANES);
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

    // Multiply latency in cycles, everything else finishes in one
    localparam int MUL_LATENCY = 4;
    localparam int LAT_W = $clog2(MUL_LATENCY);
    typedef logic [LAT_W-1:0] lat_cnt_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } alu_op_e;

    typedef enum logic {
        LANE_IDLE = 1'b0,
        LANE_BUSY = 1'b1
    } lane_state_e;

endpackage

/* project.f */
hw/rob_pkg.sv
hw/rob_ifs.sv
hw/dispatch_unit.sv
hw/exec_lane.sv
hw/reorder_buffer.sv
hw/rob_core.sv
test/rob_core_tb.sv

/* test/rob_core_tb.sv */
`timescale 1ns/1ps

module rob_core_tb import rob_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int N_IN_ORDER  = 200;
    localparam int N_RANDOM    = 300;
    localparam int PLANNED_OPS = N_IN_ORDER + N_RANDOM + ROB_DEPTH;
    localparam int TIMEOUT_NS  = PLANNED_OPS * (MUL_LATENCY + ROB_DEPTH) * 4 * CLK_PERIOD;
    localparam int DRAIN_LIMIT = ROB_DEPTH * (MUL_LATENCY + 1) * 2;

    logic      clk = 1'b0;
    logic      reset;
    logic      issue_valid;
    logic      issue_ready;
    alu_op_e   issue_op;
    word_t     issue_a;
    word_t     issue_b;
    reg_addr_t issue_rd;
    logic      commit_valid;
    logic      commit_ready;
    reg_addr_t commit_rd;
    word_t     commit_value;

    integer seed = 32'h24493bcc;
    int     errors = 0;
    int     issue_count = 0;
    int     commit_count = 0;
    logic   after_reset = 1'b0;

    // Reference model holds one entry per accepted issue in program order
    reg_addr_t exp_rd_q [$];
    word_t     exp_val_q [$];
    reg_addr_t exp_rd;
    word_t     exp_val;
    reg_addr_t first_rd;

    rob_core dut (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_rd     (issue_rd),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: simulation ran past %0d ns without finishing", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    function automatic word_t expected_result(alu_op_e op, word_t a, word_t b);
        logic [2*XLEN-1:0] product;
        product = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            // Only the low word of the product survives
            OP_MUL:  return product[XLEN-1:0];
            default: return '0;
        endcase
    endfunction

    // Multiplies are weighted up so short ops often trail them
    task automatic new_payload();
        int r;
        int v;
        r = $random(seed);
        v = $unsigned(r) % 10;
        case (v)
            0, 1, 2, 3: issue_op = OP_MUL;
            4, 5:       issue_op = OP_ADD;
            6:          issue_op = OP_SUB;
            7:          issue_op = OP_AND;
            default:    issue_op = OP_XOR;
        endcase
        issue_rd = r[REG_ADDR_W+7:8];
        issue_a  = $random(seed);
        issue_b  = $random(seed);
        if (r[20]) begin
            issue_a[XLEN-1] = 1'b1;
        end
        if (r[21]) begin
            issue_b[XLEN-1] = 1'b1;
        end
    endtask

    // Monitor samples mid-cycle where every input and output is settled
    always @(negedge clk) begin
        if (reset) begin
            check_value("commit_valid", 32'(commit_valid), 32'h0);
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                check_value("commit_valid", 32'(commit_valid), 32'h0);
                check_value("issue_ready", 32'(issue_ready), 32'h1);
                after_reset = 1'b0;
            end
            if (commit_valid && commit_ready) begin
                if (exp_rd_q.size() == 0) begin
                    $display("Commit of rd 0x%h arrived with nothing outstanding", commit_rd);
                    errors++;
                end else begin
                    exp_rd  = exp_rd_q.pop_front();
                    exp_val = exp_val_q.pop_front();
                    if (commit_count == 0) begin
                        check_value("first commit_rd", 32'(commit_rd), 32'(first_rd));
                    end
                    check_value("commit_rd", 32'(commit_rd), 32'(exp_rd));
                    check_value("commit_value", commit_value, exp_val);
                end
                commit_count++;
            end
            if (issue_valid && issue_ready) begin
                if (issue_count == 0) begin
                    first_rd = issue_rd;
                end
                exp_rd_q.push_back(issue_rd);
                exp_val_q.push_back(expected_result(issue_op, issue_a, issue_b));
                issue_count++;
            end
        end
    end

    // Payload stays put until it is taken
    task automatic run_ops(input int n, input bit random_commit);
        int target;
        int seen;
        int r;
        target = issue_count + n;
        seen = issue_count;
        while (1) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (issue_count != seen) begin
                issue_valid = 1'b0;
                seen = issue_count;
            end
            r = $random(seed);
            commit_ready = random_commit ? r[0] : 1'b1;
            if (issue_count >= target) begin
                break;
            end
            if (!issue_valid && (r[3:2] != 2'b00)) begin
                issue_valid = 1'b1;
                new_payload();
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        issue_valid = 1'b0;
        commit_ready = 1'b1;
        while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("%0d issued operations never committed", exp_rd_q.size());
            errors++;
        end
    endtask

    // With the head blocked the buffer fills at exactly ROB_DEPTH entries
    task automatic fill_check();
        int start;
        int seen;
        int c0;
        start = issue_count;
        seen = issue_count;
        commit_ready = 1'b0;
        issue_valid = 1'b1;
        new_payload();
        while (issue_count - start < ROB_DEPTH) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (issue_count != seen) begin
                seen = issue_count;
                new_payload();
            end
        end
        repeat (MUL_LATENCY + 2) begin
            @(negedge clk);
            check_value("issue_ready", 32'(issue_ready), 32'h0);
        end
        @(posedge clk);
        #DRIVE_DLY;
        issue_valid = 1'b0;
        check_value("accepted issues", 32'(issue_count - start), 32'(ROB_DEPTH));
        // Let exactly one entry retire
        c0 = commit_count;
        commit_ready = 1'b1;
        while (commit_count == c0) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        commit_ready = 1'b0;
        @(negedge clk);
        check_value("issue_ready", 32'(issue_ready), 32'h1);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    initial begin
        reset        = 1'b1;
        issue_valid  = 1'b0;
        issue_op     = OP_ADD;
        issue_a      = '0;
        issue_b      = '0;
        issue_rd     = '0;
        commit_ready = 1'b0;

        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        run_ops(N_IN_ORDER, 1'b0);
        drain();
        run_ops(N_RANDOM, 1'b1);
        drain();
        fill_check();
        drain();

        repeat (2) @(posedge clk);
        $display("Run complete: %0d issued, %0d committed, %0d errors",
                 issue_count, commit_count, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
